// ==== accel_core.f ====
+incdir+src
src/accel_core_pkg.sv
src/shift_multiplier.sv
src/neuron_mac.sv
src/weight_store.sv
src/layer_sequencer.sv
src/accel_core.sv
tb/accel_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module accel_core_tb \
    -f accel_core.f -o accel_core_sim > build.log 2>&1 &&
./obj_dir/accel_core_sim > sim.log 2>&1 || { cat build.log sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "TB FAILED" sim.log && { echo "Simulation reported failure"; exit 1; }
grep -q "TB PASSED" sim.log || { echo "Simulation ended without a result"; exit 1; }
exit 0

// ==== tb/accel_core_tb.sv ====
`timescale 1ns/1ps
`include "accel_core_defines.svh"

module accel_core_tb;

    localparam int TIMEOUT = 300;  // Wait limit in cycles, far above one full layer
    localparam int NUM = `ACCEL_NUM_NEURONS;

    logic Clock = 1'b0;
    logic reset;
    logic clear;
    logic weight_wr;
    logic [`ACCEL_ADDR_WIDTH-1:0] weight_addr;
    accel_core_pkg::t_buffer_weights weight_data;
    logic layer_start;
    accel_core_pkg::t_buffer_inout neuron_in;
    accel_core_pkg::t_buffer_inout layer_out;
    logic layer_done;
    logic busy;

    accel_core_pkg::t_buffer_weights wmodel [NUM];  // Weights the store should hold
    accel_core_pkg::t_buffer_inout expected;
    string test_name;
    logic armed;       // A layer_done is awaited
    logic done_seen;
    int checks;
    int errors;
    int test_errs;
    logic [31:0] rng;

    accel_core dut0 (.*);

    always #10 Clock = ~Clock;

    function automatic logic [31:0] next_random();
        rng ^= rng << 13;
        rng ^= rng >> 17;
        rng ^= rng << 5;
        return rng;
    endfunction

    // Bias plus the dot product of the first input_len-1 elements clamped to 8 bits
    function automatic logic signed [7:0] neuron_ref(accel_core_pkg::t_buffer_weights w,
                                                     accel_core_pkg::t_buffer_inout x);
        int len;
        int sum;
        len = (w.meta_data.input_len == 0) ? 1 : int'(w.meta_data.input_len);
        sum = int'($signed(w.data[len-1]));
        for (int i = 0; i < len - 1; i++) begin
            sum += int'($signed(x.data[i])) * int'($signed(w.data[i]));
        end
        if (sum > 127) begin
            return 8'sd127;
        end
        if (sum < -128) begin
            return -8'sd128;
        end
        return sum[7:0];
    endfunction

    function automatic accel_core_pkg::t_buffer_inout layer_ref(accel_core_pkg::t_buffer_inout x);
        accel_core_pkg::t_buffer_inout r;
        r = '0;
        r.meta_data.input_len = 4'(NUM);
        for (int n = 0; n < NUM; n++) begin
            r.data[n] = neuron_ref(wmodel[n], x);
        end
        return r;
    endfunction

    function automatic accel_core_pkg::t_buffer_inout make_input(logic [63:0] data);
        accel_core_pkg::t_buffer_inout x;
        x.data = data;  // Element i in byte i
        x.meta_data.input_len = 4'd8;
        return x;
    endfunction

    task automatic check_layer(input string name, input accel_core_pkg::t_buffer_inout exp,
                               input accel_core_pkg::t_buffer_inout act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s expected %b actual %b", name, exp, act);
        end
    endtask

    // Compares every layer_done against the model and flags any that nobody awaited
    always @(negedge Clock) begin
        if (layer_done) begin
            if (armed) begin
                check_layer(test_name, expected, layer_out);
                armed = 1'b0;
                done_seen = 1'b1;
            end else begin
                errors++;
                $display("%s: layer_done came although no result was expected", test_name);
            end
        end
    end

    task automatic set_neuron(input int n, input int len, input logic [63:0] data);
        accel_core_pkg::t_buffer_weights w;
        w.meta_data.input_len = 4'(len);
        w.data = data;
        @(posedge Clock);
        #1;
        weight_wr = 1'b1;
        weight_addr = 2'(n);
        weight_data = w;
        @(posedge Clock);
        #1;
        weight_wr = 1'b0;
        wmodel[n] = w;
    endtask

    task automatic start_layer(input accel_core_pkg::t_buffer_inout x);
        @(posedge Clock);
        #1;
        neuron_in = x;
        layer_start = 1'b1;
        @(posedge Clock);
        #1;
        layer_start = 1'b0;
    endtask

    task automatic wait_for_done();
        int cycles;
        cycles = 0;
        while (!done_seen && cycles < TIMEOUT) begin
            @(posedge Clock);
            cycles++;
        end
        if (!done_seen) begin
            errors++;
            armed = 1'b0;
            $display("%s: no layer_done within %0d cycles", test_name, TIMEOUT);
        end
    endtask

    task automatic run_check(input string name, input accel_core_pkg::t_buffer_inout x);
        test_name = name;
        expected = layer_ref(x);
        done_seen = 1'b0;
        armed = 1'b1;
        start_layer(x);
        wait_for_done();
    endtask

    task automatic end_test(input string name);
        if (errors == test_errs) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errors - test_errs);
        end
        test_errs = errors;
    endtask

    initial begin
        reset = 1'b1;
        clear = 1'b0;
        weight_wr = 1'b0;
        weight_addr = '0;
        weight_data = '0;
        layer_start = 1'b0;
        neuron_in = '0;
        armed = 1'b0;
        done_seen = 1'b0;
        checks = 0;
        errors = 0;
        test_errs = 0;
        rng = 32'h1452_f5e9;
        test_name = "reset";
        for (int n = 0; n < NUM; n++) begin
            wmodel[n] = '0;
            wmodel[n].meta_data.input_len = 4'd1;  // Store comes up bias-only
        end
        repeat (5) @(posedge Clock);
        #1 reset = 1'b0;
        check_flag("busy after reset", 1'b0, busy);
        check_flag("layer_done after reset", 1'b0, layer_done);

        set_neuron(0, 5, 64'h00000010_03FE0201);
        set_neuron(1, 4, 64'h00000000_F00204FF);
        set_neuron(2, 8, 64'h05010101_01010101);
        set_neuron(3, 3, 64'h00000000_0000F907);
        run_check("single pattern", make_input(64'h00FF0401_0205FD03));
        end_test("single pattern");

        set_neuron(0, 8, 64'h7F7F7F7F_7F7F7F7F);  // Far above 127
        set_neuron(1, 8, 64'h80808080_80808080);  // Far below -128
        set_neuron(2, 2, 64'h00000000_00008080);
        set_neuron(3, 3, 64'h00000000_007F7F7F);
        run_check("saturation", make_input(64'h007F7F7F_7F7F7F7F));
        end_test("saturation");

        set_neuron(0, 1, 64'h00000000_00000064);
        set_neuron(1, 2, 64'h00000000_0000FD05);
        set_neuron(2, 8, 64'h10FF02FE_03FD04FC);
        set_neuron(3, 1, 64'h00000000_00000081);
        run_check("mixed lengths", make_input(64'h0007F902_FE0301F6));
        end_test("mixed lengths");

        for (int r = 0; r < 30; r++) begin
            for (int n = 0; n < NUM; n++) begin
                set_neuron(n, int'(next_random() % 8) + 1, {next_random(), next_random()});
            end
            run_check($sformatf("random run %0d", r), make_input({next_random(), next_random()}));
        end
        end_test("random layers");

        // Bias of 5 for neuron 3, where a taken all-ones write would give -128
        set_neuron(3, 1, 64'h00000000_00000005);
        test_name = "ignored strobes";
        expected = layer_ref(make_input(64'h00102030_40506070));
        done_seen = 1'b0;
        armed = 1'b1;
        start_layer(make_input(64'h00102030_40506070));
        @(posedge Clock);
        #1;
        layer_start = 1'b1;  // Second start and a write while the run is in progress
        neuron_in = make_input(64'h00555555_55555555);
        weight_wr = 1'b1;
        weight_addr = 2'd3;
        weight_data = '1;
        @(posedge Clock);
        #1;
        layer_start = 1'b0;
        weight_wr = 1'b0;
        check_flag("busy during run", 1'b1, busy);
        wait_for_done();
        run_check("store after ignored write", make_input(64'h00102030_40506070));
        end_test("ignored strobes");

        test_name = "clear";
        armed = 1'b0;
        done_seen = 1'b0;
        start_layer(make_input(64'h00F0E0D0_C0B0A090));
        repeat (6) @(posedge Clock);
        #1 clear = 1'b1;
        @(posedge Clock);
        #1 clear = 1'b0;
        check_flag("busy after clear", 1'b0, busy);
        repeat (TIMEOUT) @(posedge Clock);  // Any layer_done here is an error
        run_check("run after clear", make_input(64'h00F0E0D0_C0B0A090));
        end_test("clear");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        #2ms;
        $display("Simulation hung, watchdog expired");
        $display("TB FAILED");
        $finish;
    end

endmodule

// ==== src/accel_core.sv ====
`timescale 1ns/1ps
`include "accel_core_defines.svh"

module accel_core (
    input  logic                            Clock,
    input  logic                            reset,
    input  logic                            clear,
    input  logic                            weight_wr,
    input  logic [`ACCEL_ADDR_WIDTH-1:0]    weight_addr,
    input  accel_core_pkg::t_buffer_weights weight_data,
    input  logic                            layer_start,
    input  accel_core_pkg::t_buffer_inout   neuron_in,
    output accel_core_pkg::t_buffer_inout   layer_out,
    output logic                            layer_done,
    output logic                            busy
);

    logic store_wr_en;
    logic [`ACCEL_ADDR_WIDTH-1:0] rd_addr;
    accel_core_pkg::t_buffer_weights rd_data;
    logic mac_start;
    accel_core_pkg::t_buffer_inout mac_inputs;
    logic mac_valid;
    logic signed [`ACCEL_WEIGHT_WIDTH-1:0] mac_result;

    assign store_wr_en = weight_wr && !busy;  // Weights are frozen during a run

    weight_store u_weight_store (
        .Clock   (Clock),
        .reset   (reset),
        .wr_en   (store_wr_en),
        .wr_addr (weight_addr),
        .wr_data (weight_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    layer_sequencer u_sequencer (
        .Clock       (Clock),
        .reset       (reset),
        .clear       (clear),
        .layer_start (layer_start),
        .neuron_in   (neuron_in),
        .rd_addr     (rd_addr),
        .mac_start   (mac_start),
        .mac_inputs  (mac_inputs),
        .mac_valid   (mac_valid),
        .mac_result  (mac_result),
        .layer_out   (layer_out),
        .layer_done  (layer_done),
        .busy        (busy)
    );

    neuron_mac u_neuron (
        .Clock     (Clock),
        .reset     (reset),
        .clear     (clear),
        .mac_start (mac_start),
        .neuron_in (mac_inputs),
        .weights   (rd_data),
        .result    (mac_result),
        .out_valid (mac_valid),
        .busy      ()
    );

endmodule

// ==== src/layer_sequencer.sv ====
`timescale 1ns/1ps
`include "accel_core_defines.svh"

module layer_sequencer (
    input  logic                                  Clock,
    input  logic                                  reset,
    input  logic                                  clear,
    input  logic                                  layer_start,
    input  accel_core_pkg::t_buffer_inout         neuron_in,
    output logic [`ACCEL_ADDR_WIDTH-1:0]          rd_addr,
    output logic                                  mac_start,
    output accel_core_pkg::t_buffer_inout         mac_inputs,
    input  logic                                  mac_valid,
    input  logic signed [`ACCEL_WEIGHT_WIDTH-1:0] mac_result,
    output accel_core_pkg::t_buffer_inout         layer_out,
    output logic                                  layer_done,
    output logic                                  busy
);

    localparam int AW = `ACCEL_ADDR_WIDTH;
    localparam int LW = `ACCEL_LEN_WIDTH;
    localparam int IW = $clog2(`ACCEL_MAX_LEN);
    localparam int NUM = `ACCEL_NUM_NEURONS;

    accel_core_pkg::t_seq_state state;
    logic [AW-1:0] idx;                    // Neuron in progress
    accel_core_pkg::t_buffer_inout in_q;
    accel_core_pkg::t_buffer_inout out_q;  // Results gathered during a run

    always_ff @(posedge Clock) begin
        if (reset || clear) begin
            state <= accel_core_pkg::seq_idle;
            idx <= '0;
            mac_start <= 1'b0;
            layer_done <= 1'b0;
        end else begin
            mac_start <= 1'b0;
            layer_done <= 1'b0;
            case (state)
                accel_core_pkg::seq_idle: begin
                    if (layer_start) begin
                        in_q <= neuron_in;
                        out_q <= '0;
                        out_q.meta_data.input_len <= LW'(NUM);  // One result per neuron
                        idx <= '0;
                        state <= accel_core_pkg::seq_fetch;
                    end
                end
                accel_core_pkg::seq_fetch: begin
                    mac_start <= 1'b1;  // Lines up with rd_data
                    state <= accel_core_pkg::seq_run;
                end
                accel_core_pkg::seq_run: begin
                    if (mac_valid) begin
                        out_q.data[IW'(idx)] <= mac_result;
                        if (idx == AW'(NUM - 1)) begin
                            state <= accel_core_pkg::seq_finish;
                        end else begin
                            idx <= idx + AW'(1);
                            state <= accel_core_pkg::seq_fetch;
                        end
                    end
                end
                default: begin
                    layer_out <= out_q;  // Held until the next run ends
                    layer_done <= 1'b1;
                    state <= accel_core_pkg::seq_idle;
                end
            endcase
        end
    end

    assign rd_addr = idx;
    assign mac_inputs = in_q;
    assign busy = (state != accel_core_pkg::seq_idle);

endmodule

// ==== src/weight_store.sv ====
`timescale 1ns/1ps
`include "accel_core_defines.svh"

module weight_store (
    input  logic                                Clock,
    input  logic                                reset,
    input  logic                                wr_en,
    input  logic [`ACCEL_ADDR_WIDTH-1:0]        wr_addr,
    input  accel_core_pkg::t_buffer_weights     wr_data,
    input  logic [`ACCEL_ADDR_WIDTH-1:0]        rd_addr,
    output accel_core_pkg::t_buffer_weights     rd_data
);

    localparam int NUM = `ACCEL_NUM_NEURONS;
    localparam int LW = `ACCEL_LEN_WIDTH;

    accel_core_pkg::t_buffer_weights mem [NUM];

    // After reset every neuron is bias-only with a zero bias
    always_ff @(posedge Clock) begin
        if (reset) begin
            for (int i = 0; i < NUM; i++) begin
                mem[i] <= '0;
                mem[i].meta_data.input_len <= LW'(1);
            end
        end else if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    always_ff @(posedge Clock) begin
        rd_data <= mem[rd_addr];  // One cycle read
    end

endmodule

// ==== src/neuron_mac.sv ====
`timescale 1ns/1ps
`include "accel_core_defines.svh"

module neuron_mac (
    input  logic                                  Clock,
    input  logic                                  reset,
    input  logic                                  clear,
    input  logic                                  mac_start,
    input  accel_core_pkg::t_buffer_inout         neuron_in,
    input  accel_core_pkg::t_buffer_weights       weights,
    output logic signed [`ACCEL_WEIGHT_WIDTH-1:0] result,
    output logic                                  out_valid,
    output logic                                  busy
);

    localparam int W = `ACCEL_WEIGHT_WIDTH;
    localparam int AW = `ACCEL_ACC_WIDTH;
    localparam int LW = `ACCEL_LEN_WIDTH;
    localparam int IW = $clog2(`ACCEL_MAX_LEN);
    localparam logic signed [AW-1:0] SAT_MAX = AW'((1 << (W - 1)) - 1);
    localparam logic signed [AW-1:0] SAT_MIN = -SAT_MAX - 1;

    accel_core_pkg::t_mac_state state;

    logic [LW-1:0] last_idx;   // Bias slot
    logic [LW-1:0] issue_idx;
    logic [LW-1:0] sel_idx;
    logic [LW-1:0] recv_cnt;   // Products taken so far
    logic signed [AW-1:0] acc;
    logic signed [AW-1:0] acc_sum;
    logic signed [W-1:0] sat_result;

    logic mul_in_valid;
    logic signed [W-1:0] mul_a;
    logic signed [W-1:0] mul_b;
    logic mul_out_valid;
    logic signed [2*W-1:0] mul_product;

    // Pair 0 leaves in the start cycle so the result lands at L+8.
    // The bias slot goes in as a zero product, which lets the
    // multiplier's valid bit mark the end even for a bias-only neuron.
    always_comb begin
        if (weights.meta_data.input_len == '0) begin
            last_idx = '0;
        end else begin
            last_idx = weights.meta_data.input_len - LW'(1);
        end
        sel_idx = (state == accel_core_pkg::mac_issue) ? issue_idx : '0;
        mul_in_valid = (state == accel_core_pkg::mac_issue) ||
                       (state == accel_core_pkg::mac_idle && mac_start);
        mul_a = (sel_idx == last_idx) ? '0 : neuron_in.data[sel_idx[IW-1:0]];
        mul_b = weights.data[sel_idx[IW-1:0]];
    end

    always_comb begin
        acc_sum = acc + AW'(mul_product);
        if (acc_sum > SAT_MAX) begin
            sat_result = W'(SAT_MAX);
        end else if (acc_sum < SAT_MIN) begin
            sat_result = W'(SAT_MIN);
        end else begin
            sat_result = acc_sum[W-1:0];
        end
    end

    always_ff @(posedge Clock) begin
        if (reset || clear) begin
            state <= accel_core_pkg::mac_idle;
            issue_idx <= '0;
            recv_cnt <= '0;
        end else begin
            case (state)
                accel_core_pkg::mac_idle: begin
                    if (mac_start) begin
                        acc <= AW'($signed(weights.data[last_idx[IW-1:0]]));  // Start from bias
                        issue_idx <= LW'(1);
                        recv_cnt <= '0;
                        state <= (last_idx == '0) ? accel_core_pkg::mac_drain
                                                  : accel_core_pkg::mac_issue;
                    end
                end
                accel_core_pkg::mac_issue: begin
                    issue_idx <= issue_idx + LW'(1);
                    if (issue_idx == last_idx) begin
                        state <= accel_core_pkg::mac_drain;
                    end
                end
                accel_core_pkg::mac_drain: begin
                    if (mul_out_valid) begin
                        acc <= acc_sum;
                        recv_cnt <= recv_cnt + LW'(1);
                        if (recv_cnt == last_idx) begin
                            result <= sat_result;
                            state <= accel_core_pkg::mac_done;
                        end
                    end
                end
                default: state <= accel_core_pkg::mac_idle;  // Done lasts one cycle
            endcase
        end
    end

    assign out_valid = (state == accel_core_pkg::mac_done);
    assign busy = (state != accel_core_pkg::mac_idle);

    // Clear also flushes products still in the pipeline
    shift_multiplier u_multiplier (
        .Clock     (Clock),
        .reset     (reset || clear),
        .in_valid  (mul_in_valid),
        .operand_a (mul_a),
        .operand_b (mul_b),
        .out_valid (mul_out_valid),
        .product   (mul_product)
    );

endmodule

// ==== src/shift_multiplier.sv ====
`timescale 1ns/1ps
`include "accel_core_defines.svh"

module shift_multiplier (
    input  logic                                    Clock,
    input  logic                                    reset,
    input  logic                                    in_valid,
    input  logic signed [`ACCEL_WEIGHT_WIDTH-1:0]   operand_a,
    input  logic signed [`ACCEL_WEIGHT_WIDTH-1:0]   operand_b,
    output logic                                    out_valid,
    output logic signed [2*`ACCEL_WEIGHT_WIDTH-1:0] product
);

    localparam int W = `ACCEL_WEIGHT_WIDTH;
    localparam int LAT = `ACCEL_MUL_LATENCY;  // Equal to W, each stage retires one bit

    typedef struct packed {
        logic                  valid;
        logic signed [2*W-1:0] mcand;   // Multiplicand at the weight of the next bit
        logic [W-1:0]          mplier;  // Bits still to use, LSB next
        logic signed [2*W-1:0] sum;
    } t_stage;

    t_stage entry;
    t_stage stage_in [LAT];
    t_stage pipe_q [LAT];

    always_comb begin
        entry = '0;
        entry.valid = in_valid;
        entry.mcand = (2*W)'(operand_a);  // Sign extended
        entry.mplier = operand_b;
    end

    // Stage k works on what stage k-1 left behind
    always_comb begin
        stage_in[0] = entry;
        for (int k = 1; k < LAT; k++) begin
            stage_in[k] = pipe_q[k-1];
        end
    end

    always_ff @(posedge Clock) begin
        for (int k = 0; k < LAT; k++) begin
            pipe_q[k].mcand <= stage_in[k].mcand <<< 1;
            pipe_q[k].mplier <= stage_in[k].mplier >> 1;
            if (!stage_in[k].mplier[0]) begin
                pipe_q[k].sum <= stage_in[k].sum;
            end else if (k == LAT - 1) begin
                // Two's complement sign bit weighs -2^(W-1)
                pipe_q[k].sum <= stage_in[k].sum - stage_in[k].mcand;
            end else begin
                pipe_q[k].sum <= stage_in[k].sum + stage_in[k].mcand;
            end
            if (reset) begin
                pipe_q[k].valid <= 1'b0;
            end else begin
                pipe_q[k].valid <= stage_in[k].valid;
            end
        end
    end

    assign out_valid = pipe_q[LAT-1].valid;
    assign product = pipe_q[LAT-1].sum;

endmodule

// ==== src/accel_core_pkg.sv ====
`include "accel_core_defines.svh"

package accel_core_pkg;

    typedef struct packed {
        logic [`ACCEL_LEN_WIDTH-1:0] input_len;  // Counts the bias element
    } t_meta_data;

    // One neuron's weights, bias in the last used slot
    typedef struct packed {
        t_meta_data meta_data;
        logic [`ACCEL_MAX_LEN-1:0][`ACCEL_WEIGHT_WIDTH-1:0] data;
    } t_buffer_weights;

    // Activations in or results out
    typedef struct packed {
        logic [`ACCEL_MAX_LEN-1:0][`ACCEL_WEIGHT_WIDTH-1:0] data;
        t_meta_data meta_data;
    } t_buffer_inout;

    typedef enum logic [1:0] {
        mac_idle,
        mac_issue,   // Feeding operand pairs
        mac_drain,   // Collecting products
        mac_done
    } t_mac_state;

    typedef enum logic [1:0] {
        seq_idle,
        seq_fetch,   // Weight read in flight
        seq_run,
        seq_finish
    } t_seq_state;

endpackage

// ==== src/accel_core_defines.svh ====
`ifndef ACCEL_CORE_DEFINES_SVH
`define ACCEL_CORE_DEFINES_SVH

// Weights, activations and results share one element width
`define ACCEL_WEIGHT_WIDTH 8

`define ACCEL_MAX_LEN 8        // Weight vector length with the bias
`define ACCEL_LEN_WIDTH 4      // Holds lengths 1 to 8

`define ACCEL_NUM_NEURONS 4
`define ACCEL_ADDR_WIDTH 2     // Neuron select in the weight store

// Wide enough that a full dot product never wraps
`define ACCEL_ACC_WIDTH 32

`define ACCEL_MUL_LATENCY 8    // One stage per multiplier bit

`endif
